//--- include/sd_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD receive path settings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

// Words held by the receive FIFO, power of two
`define SD_FIFO_DEPTH 8

// Pointer width: log2 of depth plus the wrap bit
`define SD_FIFO_ADR_SIZE 4

// Data nibbles per block, multiple of 8 (64 nibbles = 32 bytes)
`define SD_BLK_NIBBLES 64

// Nibble order inside a FIFO word
// 1: first nibble of a word goes to bits 31:28
// 0: first nibble of a word goes to bits 3:0
`define SD_BIG_ENDIAN 0

`endif

//--- source/sd_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD receive path types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "sd_settings.svh"

package sd_pkg;

   // One sample of the 4-bit DAT bus
   typedef logic [3:0] nibble_t;

   // Eight nibbles packed for the host side
   typedef logic [31:0] word_t;

   // CRC16 register of a single DAT line
   typedef logic [15:0] crc16_t;

   // FIFO fill level, wide enough to hold the full depth
   typedef logic [`SD_FIFO_ADR_SIZE-1:0] level_t;

endpackage

`default_nettype wire

//--- source/sd_crc16.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial CRC16 for one DAT line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module sd_crc16 import sd_pkg::*; (
   input  wire    wclk,
   input  wire    rst,
   input  wire    clr_i,                   // Back to zero before a block
   input  wire    en_i,                    // Shift in one data bit
   input  wire    bit_i,
   output crc16_t crc_o
);

   // CCITT polynomial x^16 + x^12 + x^5 + 1
   localparam crc16_t POLY = 16'h1021;

   logic fb;

   assign fb = crc_o[15] ^ bit_i;          // Feedback from the top bit

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         crc_o <= '0;
      end else if (clr_i) begin
         crc_o <= '0;
      end else if (en_i) begin
         if (fb)
            crc_o <= {crc_o[14:0], 1'b0} ^ POLY;
         else
            crc_o <= {crc_o[14:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

//--- source/sd_data_rx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD 4-bit data block receiver
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "sd_settings.svh"

module sd_data_rx import sd_pkg::*; (
   input  wire          wclk,
   input  wire          rst,
   input  wire          rx_en_i,            // Arms the receiver while idle
   input  wire nibble_t dat_i,              // DAT[3:0], idle high
   output nibble_t      nib_o,
   output logic         nib_wr_o,           // One pulse per data nibble
   output logic         busy_o,
   output logic         blk_done_o,
   output logic         crc_err_o
);

   // Counter covers the data phase and the 16 CRC bits
   localparam int CNT_W = $clog2(`SD_BLK_NIBBLES + 16);
   localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(`SD_BLK_NIBBLES - 1);
   localparam logic [CNT_W-1:0] LAST_CRC = CNT_W'(15);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DATA,
      ST_CRC,
      ST_END
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;
   logic             start;
   logic             crc_en;
   logic             crc_bad;
   crc16_t           crc_calc [4];
   crc16_t           crc_rx [4];

   // All four lines low while armed and idle
   assign start  = (state == ST_IDLE) && rx_en_i && (dat_i == 4'h0);
   assign crc_en = (state == ST_DATA);
   assign busy_o = (state != ST_IDLE) || start;

   for (genvar g = 0; g < 4; g++) begin : g_crc
      sd_crc16 u_crc (
         .wclk  (wclk),
         .rst   (rst),
         .clr_i (start),
         .en_i  (crc_en),
         .bit_i (dat_i[g]),
         .crc_o (crc_calc[g])
      );
   end

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               cnt <= '0;
               if (start)
                  state <= ST_DATA;
            end
            ST_DATA: begin
               if (cnt == LAST_NIB) begin
                  cnt   <= '0;
                  state <= ST_CRC;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_CRC: begin
               if (cnt == LAST_CRC) begin
                  cnt   <= '0;
                  state <= ST_END;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               state <= ST_IDLE;            // End bit taken, wait for next arm
            end
         endcase
      end
   end

   // Received CRC bits arrive MSB first on each line
   always_ff @(posedge wclk) begin
      if (state == ST_CRC) begin
         for (int i = 0; i < 4; i++)
            crc_rx[i] <= {crc_rx[i][14:0], dat_i[i]};
      end
   end

   always_comb begin
      crc_bad = 1'b0;
      for (int i = 0; i < 4; i++) begin
         if (crc_rx[i] != crc_calc[i])
            crc_bad = 1'b1;
      end
   end

   // Nibble leaves one cycle after it is sampled
   always_ff @(posedge wclk) begin
      if (state == ST_DATA)
         nib_o <= dat_i;
   end

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         nib_wr_o   <= 1'b0;
         blk_done_o <= 1'b0;
         crc_err_o  <= 1'b0;
      end else begin
         nib_wr_o   <= (state == ST_DATA);
         blk_done_o <= (state == ST_END);
         if (start)
            crc_err_o <= 1'b0;              // Cleared by the next block
         else if (state == ST_END)
            crc_err_o <= crc_bad || (dat_i != 4'hF);
      end
   end

endmodule

`default_nettype wire

//--- source/sd_rx_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nibble packer and receive word FIFO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "sd_settings.svh"

module sd_rx_fifo import sd_pkg::*; (
   input  wire          wclk,
   input  wire          rst,
   input  wire nibble_t d_i,
   input  wire          wr_i,               // Nibble strobe from the receiver
   input  wire          rd_i,               // Pop, ignored while empty
   output word_t        q_o,                // Oldest word, fall-through
   output logic         full_o,
   output logic         empty_o,
   output level_t       level_o,
   output logic         overflow_o          // Sticky until reset
);

   localparam int DEPTH = `SD_FIFO_DEPTH;
   localparam int AW    = `SD_FIFO_ADR_SIZE;
   localparam bit BIG   = `SD_BIG_ENDIAN;

   word_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;                   // MSB is the wrap bit
   logic [AW-1:0] rd_ptr;
   logic [7:0]    we;                       // One-hot nibble slot
   word_t         hold;
   word_t         word_in;
   logic          word_done;
   logic          mem_we;
   logic          mem_re;

   // Holding register with the incoming nibble merged into its slot
   always_comb begin
      word_in = hold;
      for (int i = 0; i < 8; i++) begin
         if (we[i])
            word_in[4*(BIG ? 7 - i : i) +: 4] = d_i;
      end
   end

   assign word_done = wr_i && we[7];
   assign mem_we    = word_done && !full_o;
   assign mem_re    = rd_i && !empty_o;

   always_ff @(posedge wclk or posedge rst) begin
      if (rst)
         we <= 8'h01;
      else if (wr_i)
         we <= {we[6:0], we[7]};
   end

   always_ff @(posedge wclk) begin
      if (wr_i)
         hold <= word_in;
   end

   // Eighth nibble goes straight into memory with the rest
   always_ff @(posedge wclk) begin
      if (mem_we)
         mem[wr_ptr[AW-2:0]] <= word_in;
   end

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (mem_we)
            wr_ptr <= wr_ptr + 1'b1;        // Wraps into the wrap bit
         if (mem_re)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge wclk or posedge rst) begin
      if (rst)
         overflow_o <= 1'b0;
      else if (word_done && full_o)
         overflow_o <= 1'b1;                // Word dropped, packing goes on
   end

   // Same slot, different lap means full
   assign full_o  = (wr_ptr[AW-2:0] == rd_ptr[AW-2:0]) &&
                    (wr_ptr[AW-1] != rd_ptr[AW-1]);
   assign empty_o = (wr_ptr == rd_ptr);
   assign level_o = wr_ptr - rd_ptr;
   assign q_o     = mem[rd_ptr[AW-2:0]];

endmodule

`default_nettype wire

//--- source/sd_rx_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD receive data path top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module sd_rx_top import sd_pkg::*; (
   input  wire          wclk,
   input  wire          rst,
   input  wire          rx_en_i,
   input  wire nibble_t dat_i,              // Card DAT lines
   input  wire          rd_i,
   output word_t        q_o,
   output logic         empty_o,
   output logic         full_o,
   output level_t       level_o,
   output logic         overflow_o,
   output logic         busy_o,
   output logic         blk_done_o,
   output logic         crc_err_o
);

   nibble_t nib;                            // Data nibble toward the packer
   logic    nib_wr;

   sd_data_rx u_data_rx (
      .wclk       (wclk),
      .rst        (rst),
      .rx_en_i    (rx_en_i),
      .dat_i      (dat_i),
      .nib_o      (nib),
      .nib_wr_o   (nib_wr),
      .busy_o     (busy_o),
      .blk_done_o (blk_done_o),
      .crc_err_o  (crc_err_o)
   );

   sd_rx_fifo u_rx_fifo (
      .wclk       (wclk),
      .rst        (rst),
      .d_i        (nib),
      .wr_i       (nib_wr),
      .rd_i       (rd_i),
      .q_o        (q_o),
      .full_o     (full_o),
      .empty_o    (empty_o),
      .level_o    (level_o),
      .overflow_o (overflow_o)
   );

endmodule

`default_nettype wire

//--- test/sd_rx_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD receive path testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "sd_settings.svh"

module sd_rx_tb import sd_pkg::*; ();

   localparam int DEPTH  = `SD_FIFO_DEPTH;
   localparam int BLOCKS = 6;                 // Blocks sent over all tests
   localparam longint TIMEOUT_NS = BLOCKS * (`SD_BLK_NIBBLES + 20) * 8 * 3;

   logic    wclk;
   logic    rst;
   logic    rx_en_i;
   nibble_t dat_i;
   logic    rd_i;
   word_t   q_o;
   logic    empty_o;
   logic    full_o;
   level_t  level_o;
   logic    overflow_o;
   logic    busy_o;
   logic    blk_done_o;
   logic    crc_err_o;

   integer  seed;
   int      errors;
   int      checks;
   int      tests;
   int      err_mark;
   string   cur_test;
   int      rd_mode;                          // Reads never (0), at random (1) or always (2)
   logic    lvl_chk;
   word_t   exp_q [$];                        // Words the FIFO should hold
   int      m_level;
   logic    m_ovf;
   logic    stage;                            // Word in flight toward memory
   word_t   stage_word;

   sd_rx_top uut (
      .wclk       (wclk),
      .rst        (rst),
      .rx_en_i    (rx_en_i),
      .dat_i      (dat_i),
      .rd_i       (rd_i),
      .q_o        (q_o),
      .empty_o    (empty_o),
      .full_o     (full_o),
      .level_o    (level_o),
      .overflow_o (overflow_o),
      .busy_o     (busy_o),
      .blk_done_o (blk_done_o),
      .crc_err_o  (crc_err_o)
   );

   always #4 wclk = ~wclk;

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      checks++;
      if (expected !== actual) begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_level(input string name, input level_t expected, input level_t actual);
      checks++;
      if (expected !== actual) begin
         $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      checks++;
      if (expected !== actual) begin
         $display("** Error %s: expected %b, actual %b", name, expected, actual);
         errors++;
      end
   endtask

   // Bitwise CCITT update for x^16 + x^12 + x^5 + 1
   function automatic crc16_t crc_shift(input crc16_t c, input logic b);
      crc16_t r;
      r = {c[14:0], 1'b0};
      if (c[15] ^ b)
         r = r ^ 16'h1021;
      return r;
   endfunction

   function automatic word_t pack_nibble(input word_t w, input int slot, input nibble_t n);
      word_t r;
      r = w;
      if (`SD_BIG_ENDIAN)
         r[4*(7-slot) +: 4] = n;
      else
         r[4*slot +: 4] = n;
      return r;
   endfunction

   // One bus cycle with an optional pop and a model update after the edge
   task automatic drive_cycle(input nibble_t d, input logic fin, input word_t w);
      logic  do_rd;
      logic  land;
      word_t land_word;
      do_rd = (m_level > 0) && (rd_mode == 2 || (rd_mode == 1 && ($random(seed) & 1)));
      if (do_rd)
         check_word({cur_test, "/q_o"}, exp_q[0], q_o);
      dat_i = d;
      rd_i  = do_rd;
      @(posedge wclk);
      #1;
      land       = stage;
      land_word  = stage_word;
      stage      = fin;                       // Eighth nibble reaches memory one edge later
      stage_word = w;
      if (land) begin
         if (m_level == DEPTH) begin
            m_ovf = 1'b1;                     // Dropped while full
         end else begin
            exp_q.push_back(land_word);
            m_level++;
         end
      end
      if (do_rd) begin
         void'(exp_q.pop_front());
         m_level--;
         if (lvl_chk)
            check_level({cur_test, "/level_o"}, level_t'(m_level), level_o);
      end
   endtask

   task automatic send_block(input int flip_line, input int flip_bit);
      crc16_t  crc [4];
      nibble_t n;
      word_t   w;
      int      i;
      int      k;
      int      l;
      for (l = 0; l < 4; l++)
         crc[l] = '0;
      w = '0;
      drive_cycle(4'hF, 1'b0, '0);
      drive_cycle(4'h0, 1'b0, '0);            // Start bit
      check_flag({cur_test, "/busy_o"}, 1'b1, busy_o);
      for (i = 0; i < `SD_BLK_NIBBLES; i++) begin
         n = $random(seed);
         for (l = 0; l < 4; l++)
            crc[l] = crc_shift(crc[l], n[l]);
         w = pack_nibble(w, i % 8, n);
         drive_cycle(n, (i % 8) == 7, w);
      end
      for (k = 15; k >= 0; k--) begin
         for (l = 0; l < 4; l++)
            n[l] = crc[l][k] ^ (l == flip_line && k == flip_bit);
         drive_cycle(n, 1'b0, '0);
      end
      check_flag({cur_test, "/busy_o"}, 1'b1, busy_o);
      drive_cycle(4'hF, 1'b0, '0);            // End bit
   endtask

   task automatic wait_done(input logic exp_err);
      int   n;
      logic seen;
      seen = 1'b0;
      for (n = 0; n < 8 && !seen; n++) begin
         if (blk_done_o) begin
            seen = 1'b1;
            check_flag({cur_test, "/crc_err_o"}, exp_err, crc_err_o);
            check_flag({cur_test, "/busy_o"}, 1'b0, busy_o);
         end else begin
            drive_cycle(4'hF, 1'b0, '0);
         end
      end
      if (!seen) begin
         $display("%s: blk_done_o did not pulse after the end bit", cur_test);
         errors++;
      end
   endtask

   task automatic drain_fifo();
      int n;
      rd_mode = 2;
      for (n = 0; n < 2 * DEPTH + 4 && (m_level > 0 || stage); n++)
         drive_cycle(4'hF, 1'b0, '0);
      check_flag({cur_test, "/empty_o"}, 1'b1, empty_o);
      check_level({cur_test, "/level_o"}, '0, level_o);
      if (exp_q.size() != 0) begin
         $display("%s: %0d expected words never came out", cur_test, exp_q.size());
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      err_mark = errors;
      tests++;
   endtask

   task automatic end_test();
      if (errors == err_mark)
         $display("Test %s: passed", cur_test);
      else
         $display("Test %s: failed with %0d errors", cur_test, errors - err_mark);
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: simulation ran past %0d ns", TIMEOUT_NS);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      seed = 72;
      errors = 0;
      checks = 0;
      tests = 0;
      wclk = 1'b0;
      rst = 1'b1;
      rx_en_i = 1'b0;
      dat_i = 4'hF;                           // Idle lines are high
      rd_i = 1'b0;
      rd_mode = 0;
      lvl_chk = 1'b0;
      m_level = 0;
      m_ovf = 1'b0;
      stage = 1'b0;
      stage_word = '0;
      repeat (4) @(posedge wclk);
      #1;
      rst = 1'b0;

      begin_test("reset");
      check_flag("reset/empty_o", 1'b1, empty_o);
      check_level("reset/level_o", '0, level_o);
      check_flag("reset/full_o", 1'b0, full_o);
      check_flag("reset/overflow_o", 1'b0, overflow_o);
      check_flag("reset/busy_o", 1'b0, busy_o);
      check_flag("reset/blk_done_o", 1'b0, blk_done_o);
      check_flag("reset/crc_err_o", 1'b0, crc_err_o);
      end_test();
      rx_en_i = 1'b1;

      begin_test("good_block");
      rd_mode = 1;
      send_block(-1, 0);
      wait_done(1'b0);
      drain_fifo();
      end_test();

      begin_test("crc_error");
      rd_mode = 1;
      send_block($random(seed) & 3, $random(seed) & 15);
      wait_done(1'b1);
      drain_fifo();
      end_test();

      begin_test("fill");
      rd_mode = 0;
      send_block(-1, 0);
      wait_done(1'b0);
      check_flag("fill/full_o", 1'b1, full_o);
      check_level("fill/level_o", level_t'(DEPTH), level_o);
      check_flag("fill/overflow_o", m_ovf, overflow_o);
      send_block(-1, 0);                      // Every word of this block is dropped
      wait_done(1'b0);
      check_flag("fill/overflow_o", m_ovf, overflow_o);
      drain_fifo();
      end_test();

      begin_test("two_blocks");
      rd_mode = 1;
      lvl_chk = 1'b1;
      send_block(-1, 0);
      wait_done(1'b0);
      send_block(-1, 0);
      wait_done(1'b0);
      drain_fifo();
      check_flag("two_blocks/overflow_o", m_ovf, overflow_o);
      end_test();

      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
source/sd_pkg.sv
source/sd_crc16.sv
source/sd_data_rx.sv
source/sd_rx_fifo.sv
source/sd_rx_top.sv
test/sd_rx_tb.sv

//--- Bender.yml
package:
  name: sd_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/sd_pkg.sv
      - source/sd_crc16.sv
      - source/sd_data_rx.sv
      - source/sd_rx_fifo.sv
      - source/sd_rx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/sd_rx_tb.sv
